// ==== design/barrel_shifter.sv ====
// --------------------------------------------------------------------
// logical shifter, zero fill in both directions, amount 0..31
// --------------------------------------------------------------------
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module barrel_shifter
   import core_pkg::*;
(
   input  word_t                   a,
   input  logic [`CPU_SHAMT_W-1:0] shamt,
   input  logic                    left,
   output word_t                   y
);

   word_t stage [`CPU_SHAMT_W+1];

   assign stage[0] = a;

   // stage i moves by 2**i when shamt[i] is set
   for (genvar i = 0; i < `CPU_SHAMT_W; i++) begin : g_stage
      word_t moved;

      assign moved        = left ? stage[i] << (2 ** i) : stage[i] >> (2 ** i);
      assign stage[i + 1] = shamt[i] ? moved : stage[i];
   end

   assign y = stage[`CPU_SHAMT_W];

endmodule

// ==== design/core_pkg.sv ====
// --------------------------------------------------------------------
// datapath types shared by register file, execute unit and PC logic
// --------------------------------------------------------------------
`include "cpu_cfg.svh"

package core_pkg;

   typedef logic [`CPU_XLEN-1:0]    word_t;
   typedef logic [`CPU_PC_W-1:0]    pc_t;
   typedef logic [`CPU_RADDR_W-1:0] raddr_t;

   // both read ports of the register file
   typedef struct packed {
      word_t a;
      word_t b;
   } operands_t;

   typedef struct packed {
      logic   en;
      raddr_t addr;
      word_t  data;
   } wr_req_t;

endpackage

// ==== design/cpu_cfg.svh ====
// --------------------------------------------------------------------
// fixed widths of the core, tied to the 16-bit instruction format.
// changing a value here alone does not re-encode the instruction word
// --------------------------------------------------------------------
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath word
`define CPU_XLEN      32
// program counter and branch target
`define CPU_PC_W      8
`define CPU_INSTR_W   16

// register file
`define CPU_REG_CNT   16
`define CPU_RADDR_W   4

// LOADI immediate, zero-extended to the word
`define CPU_IMM_W     8
`define CPU_ZTEST_W   8   // low bits of A tested by JZ/JNZ
`define CPU_SHAMT_W   5   // only B[4:0] drives the shifter

`endif

// ==== design/cpu_top.sv ====
// --------------------------------------------------------------------
// single-cycle core top. one instruction per clock on code, fetched
// externally for the current pc; no stall input
// --------------------------------------------------------------------
`timescale 1ns/100ps

module cpu_top
   import isa_pkg::*, core_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  instr_t code,
   output pc_t    pc,
   output pc_t    next_pc,
   output word_t  result,
   output logic   write_en,
   output logic   imm_en,
   output logic   branch_en
);

   ctrl_t     ctrl;
   operands_t ops;
   wr_req_t   wr;

   assign wr       = '{en: ctrl.wr_en, addr: ctrl.rd, data: result};
   assign write_en = ctrl.wr_en;
   assign imm_en   = ctrl.imm_sel;

   instr_decoder u_decoder (.code(code), .ctrl(ctrl));

   pc_unit u_pc (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctrl      (ctrl),
      .ra_val    (ops.a),
      .pc        (pc),
      .next_pc   (next_pc),
      .branch_en (branch_en)
   );

   reg_file u_regs (.clk(clk), .rst_n(rst_n), .ra(ctrl.ra), .rb(ctrl.rb), .wr(wr), .ops(ops));

   exec_unit u_exec (.ctrl(ctrl), .ops(ops), .result(result));

endmodule

// ==== design/exec_unit.sv ====
// --------------------------------------------------------------------
// ALU plus immediate select. add and subtract share one adder,
// results are modulo 2**32. codes 110/111 give zero
// --------------------------------------------------------------------
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module exec_unit
   import isa_pkg::*, core_pkg::*;
(
   input  ctrl_t     ctrl,
   input  operands_t ops,
   output word_t     result
);

   logic  sub;
   word_t b_in;
   word_t sum;
   word_t shifted;
   word_t alu_y;

   assign sub  = ctrl.alu_op == ALU_SUB;
   assign b_in = ops.b ^ {`CPU_XLEN{sub}};   // a + ~b + 1 for subtract
   assign sum  = ops.a + b_in + {{(`CPU_XLEN-1){1'b0}}, sub};

   barrel_shifter u_shifter (
      .a     (ops.a),
      .shamt (ops.b[`CPU_SHAMT_W-1:0]),
      .left  (ctrl.alu_op == ALU_SLL),
      .y     (shifted)
   );

   always_comb begin
      case (ctrl.alu_op)
         ALU_SLL, ALU_SRL: alu_y = shifted;
         ALU_ADD, ALU_SUB: alu_y = sum;
         ALU_AND:          alu_y = ops.a & ops.b;
         ALU_XNOR:         alu_y = ops.a ~^ ops.b;
         default:          alu_y = '0;   // reserved, never written back
      endcase
   end

   assign result = ctrl.imm_sel ? {{(`CPU_XLEN-`CPU_IMM_W){1'b0}}, ctrl.imm} : alu_y;

endmodule

// ==== design/instr_decoder.sv ====
// --------------------------------------------------------------------
// purely combinational decode. unused 1xxx opcodes and ALU codes
// 110/111 come out as no-operations
// --------------------------------------------------------------------
`timescale 1ns/100ps

module instr_decoder
   import isa_pkg::*;
(
   input  instr_t code,
   output ctrl_t  ctrl
);

   logic is_alu;
   logic alu_valid;

   assign is_alu    = ~code.op[3];
   assign alu_valid = code.op[2:1] != 2'b11;   // 110 and 111 reserved

   always_comb begin
      ctrl.alu_op  = alu_op_e'(code.op[2:0]);
      ctrl.imm_sel = code.op == OP_LOADI;
      ctrl.jz      = code.op == OP_JZ;
      ctrl.jnz     = code.op == OP_JNZ;
      ctrl.stop    = code.op == OP_STOP;
      ctrl.wr_en   = (is_alu && alu_valid) || ctrl.imm_sel;

      // register fields are taken raw, unused ones are don't care
      ctrl.rd      = code.f_s;
      ctrl.ra      = code.f_a;
      ctrl.rb      = code.f_b;
      ctrl.imm     = {code.f_a, code.f_b};
      ctrl.target  = {code.f_s, code.f_b};   // f_a holds the tested reg
   end

endmodule

// ==== design/isa_pkg.sv ====
// --------------------------------------------------------------------
// instruction format and decoded control. ALU codes 110 and 111 are
// reserved and decode to a no-operation
// --------------------------------------------------------------------
`include "cpu_cfg.svh"

package isa_pkg;

   typedef struct packed {
      logic [3:0]              op;
      logic [`CPU_RADDR_W-1:0] f_s;  // rd, or target high nibble
      logic [`CPU_RADDR_W-1:0] f_a;
      logic [`CPU_RADDR_W-1:0] f_b;
   } instr_t;

   // opcodes with bit 15 set
   localparam logic [3:0] OP_JZ    = 4'b1000;
   localparam logic [3:0] OP_JNZ   = 4'b1001;
   localparam logic [3:0] OP_LOADI = 4'b1010;
   localparam logic [3:0] OP_STOP  = 4'b1111;

   typedef enum logic [2:0] {
      ALU_SLL  = 3'b000,
      ALU_SRL  = 3'b001,
      ALU_ADD  = 3'b010,
      ALU_SUB  = 3'b011,
      ALU_AND  = 3'b100,
      ALU_XNOR = 3'b101
   } alu_op_e;

   typedef struct packed {
      alu_op_e                 alu_op;
      logic                    wr_en;
      logic                    imm_sel;
      logic                    jz;
      logic                    jnz;
      logic                    stop;
      logic [`CPU_RADDR_W-1:0] rd;
      logic [`CPU_RADDR_W-1:0] ra;
      logic [`CPU_RADDR_W-1:0] rb;
      logic [`CPU_IMM_W-1:0]   imm;
      logic [`CPU_PC_W-1:0]    target;
   } ctrl_t;

endpackage

// ==== design/pc_unit.sv ====
// --------------------------------------------------------------------
// 8-bit PC, wraps from 255 to 0. priority of the next PC is reset,
// stop, branch, increment
// --------------------------------------------------------------------
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module pc_unit
   import isa_pkg::*, core_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  ctrl_t ctrl,
   input  word_t ra_val,
   output pc_t   pc,
   output pc_t   next_pc,
   output logic  branch_en
);

   logic a_zero;

   assign a_zero    = ra_val[`CPU_ZTEST_W-1:0] == '0;
   assign branch_en = (ctrl.jz && a_zero) || (ctrl.jnz && !a_zero);

   always_comb begin
      if (!rst_n)
         next_pc = '0;
      else if (ctrl.stop)
         next_pc = pc;            // hold on STOP
      else if (branch_en)
         next_pc = ctrl.target;
      else
         next_pc = pc + 1'b1;
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         pc <= '0;
      else
         pc <= next_pc;
   end

endmodule

// ==== design/reg_file.sv ====
// --------------------------------------------------------------------
// 16x32 register file, two async read ports, one write port.
// contents are undefined after reset. a read during a write to the
// same register sees the old value
// --------------------------------------------------------------------
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module reg_file
   import core_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  raddr_t    ra,
   input  raddr_t    rb,
   input  wr_req_t   wr,
   output operands_t ops
);

   word_t regs [`CPU_REG_CNT];

   always_ff @(posedge clk) begin
      if (rst_n && wr.en)   // writes held off during reset
         regs[wr.addr] <= wr.data;
   end

   // combinational reads, no bypass
   assign ops.a = regs[ra];
   assign ops.b = regs[rb];

endmodule

// ==== files.f ====
+incdir+design
design/isa_pkg.sv
design/core_pkg.sv
design/instr_decoder.sv
design/pc_unit.sv
design/reg_file.sv
design/barrel_shifter.sv
design/exec_unit.sv
design/cpu_top.sv
test/cpu_chk.sv
test/tb_clk_gen.sv
test/cpu_tb.sv

// ==== test/cpu_chk.sv ====
// ----------------------------------------------------------------------
// assertions bound into cpu_top. failures are counted in fail_cnt,
// which the testbench reads at the end of the run
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module cpu_chk
   import isa_pkg::*, core_pkg::*;
(
   input logic   clk,
   input logic   rst_n,
   input instr_t code,
   input pc_t    pc,
   input pc_t    next_pc,
   input logic   write_en,
   input logic   branch_en
);

   int fail_cnt = 0;

   a_branch_target: assert property (@(posedge clk) disable iff (!rst_n)
      branch_en |-> next_pc == {code.f_s, code.f_b})
      else begin
         $error("taken branch did not select the target field");
         fail_cnt++;
      end

   a_stop_hold: assert property (@(posedge clk) disable iff (!rst_n)
      code.op == 4'hf |-> next_pc == pc)
      else begin
         $error("STOP did not hold the PC");
         fail_cnt++;
      end

   a_stop_no_write: assert property (@(posedge clk) disable iff (!rst_n)
      code.op == 4'hf |-> !write_en)
      else begin
         $error("STOP came with a register write");
         fail_cnt++;
      end

   // first cycle out of reset
   a_reset_pc: assert property (@(posedge clk) $rose(rst_n) |-> pc == '0)
      else begin
         $error("PC not zero after reset");
         fail_cnt++;
      end

endmodule

bind cpu_top cpu_chk u_chk (
   .clk       (clk),
   .rst_n     (rst_n),
   .code      (code),
   .pc        (pc),
   .next_pc   (next_pc),
   .write_en  (write_en),
   .branch_en (branch_en)
);

// ==== test/cpu_tb.sv ====
// ----------------------------------------------------------------------
// self-checking testbench. code is fetched from a local ROM at next_pc
// on every rising edge; ROM entry 0 is a no-operation so reset sees one
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module cpu_tb
   import isa_pkg::*, core_pkg::*;
();

   localparam instr_t NOP_CODE = 16'hb000;   // unused 1xxx opcode

   typedef struct packed {
      word_t result;
      logic  write_en;
      logic  imm_en;
      logic  branch_en;
      pc_t   next_pc;
   } expect_t;

   logic   clk;
   logic   rst_n;
   instr_t code;
   pc_t    pc;
   pc_t    next_pc;
   word_t  result;
   logic   write_en;
   logic   imm_en;
   logic   branch_en;

   instr_t rom [1 << `CPU_PC_W];
   int     wp = 0;
   int     prog_len = 0;
   logic   rom_ready = 1'b0;
   word_t  model_regs [`CPU_REG_CNT];
   pc_t    model_pc = '0;
   int     stop_cycles = 0;

   tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

   cpu_top u_cpu_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .code      (code),
      .pc        (pc),
      .next_pc   (next_pc),
      .result    (result),
      .write_en  (write_en),
      .imm_en    (imm_en),
      .branch_en (branch_en)
   );

   function automatic instr_t enc_alu(input logic [2:0] op, input logic [3:0] rd,
                                      input logic [3:0] ra, input logic [3:0] rb);
      return {1'b0, op, rd, ra, rb};
   endfunction

   function automatic instr_t enc_loadi(input logic [3:0] rd, input logic [7:0] imm);
      return {4'b1010, rd, imm};
   endfunction

   // jnz selects 1001 over 1000
   function automatic instr_t enc_jump(input logic jnz, input logic [3:0] ra,
                                       input int target);
      return {3'b100, jnz, target[7:4], ra, target[3:0]};
   endfunction

   function automatic void emit(input instr_t c);
      rom[wp] = c;
      wp++;
   endfunction

   // expected outputs for one instruction against the model state
   function automatic expect_t predict(input instr_t c, input pc_t cur_pc);
      expect_t e;
      word_t   a;
      word_t   b;
      a = model_regs[c.f_a];
      b = model_regs[c.f_b];
      e = '0;
      e.next_pc = cur_pc + 8'd1;
      if (!c.op[3]) begin
         e.write_en = c.op[2:0] < 3'd6;
         case (c.op[2:0])
            3'd0:    e.result = a << b[4:0];
            3'd1:    e.result = a >> b[4:0];
            3'd2:    e.result = a + b;
            3'd3:    e.result = a - b;
            3'd4:    e.result = a & b;
            3'd5:    e.result = ~(a ^ b);
            default: e.result = '0;
         endcase
      end else begin
         case (c.op)
            4'b1010: begin
               e.result   = {24'd0, c.f_a, c.f_b};
               e.write_en = 1'b1;
               e.imm_en   = 1'b1;
            end
            4'b1000: e.branch_en = a[7:0] == 8'd0;
            4'b1001: e.branch_en = a[7:0] != 8'd0;
            4'b1111: e.next_pc = cur_pc;
            default: e.next_pc = cur_pc + 8'd1;
         endcase
      end
      if (e.branch_en)
         e.next_pc = {c.f_s, c.f_b};
      return e;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] expd);
      if (got !== expd)
         abort_run($sformatf("Fail at %0t: %s got %0h expected %0h",
                             $time, name, got, expd));
   endtask

   task automatic end_run();
      if (u_cpu_top.u_chk.fail_cnt == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   endtask

   initial begin : build_rom
      int loop;
      void'($urandom(32'h82b7));
      code = NOP_CODE;
      for (int i = 0; i < (1 << `CPU_PC_W); i++)
         rom[i] = {4'hf, i[7:0], 4'h0};   // STOP, address in the spare bits
      emit(NOP_CODE);
      for (int r = 0; r < `CPU_REG_CNT; r++)
         emit(enc_loadi(4'(r), 8'($urandom_range(255, 0))));
      for (int n = 0; n < 40; n++)
         emit(enc_alu(3'($urandom_range(7, 0)), 4'($urandom_range(15, 0)),
                      4'($urandom_range(15, 0)), 4'($urandom_range(15, 0))));
      emit(enc_alu(3'b110, 4'd1, 4'd2, 4'd3));
      emit(enc_alu(3'b111, 4'd4, 4'd5, 4'd6));
      for (int op = 4'hb; op <= 4'he; op++)
         emit({4'(op), 12'($urandom)});
      // shift amounts 0, 31 and 63 (only B[4:0] counts)
      emit(enc_loadi(4'd14, 8'd0));
      emit(enc_loadi(4'd15, 8'd31));
      emit(enc_loadi(4'd13, 8'ha5));
      emit(enc_loadi(4'd2, 8'h3f));
      emit(enc_alu(3'd0, 4'd12, 4'd13, 4'd15));
      emit(enc_alu(3'd1, 4'd11, 4'd12, 4'd15));
      emit(enc_alu(3'd1, 4'd10, 4'd12, 4'd2));
      emit(enc_alu(3'd0, 4'd9, 4'd13, 4'd14));
      emit(enc_alu(3'd1, 4'd8, 4'd13, 4'd14));
      // countdown with JNZ
      emit(enc_loadi(4'd1, 8'd3));
      emit(enc_loadi(4'd2, 8'd1));
      loop = wp;
      emit(enc_alu(3'd3, 4'd1, 4'd1, 4'd2));
      emit(enc_jump(1'b1, 4'd1, loop));
      // r3 = 0x100, low byte zero with upper bits set
      emit(enc_loadi(4'd3, 8'd1));
      emit(enc_loadi(4'd4, 8'd8));
      emit(enc_alu(3'd0, 4'd3, 4'd3, 4'd4));
      emit(enc_jump(1'b1, 4'd3, 8'hf0));   // not taken
      emit(enc_jump(1'b1, 4'd12, 8'hf0));  // 0x80000000, low byte zero
      emit(enc_jump(1'b0, 4'd3, wp + 2));  // taken, skips one
      emit(enc_loadi(4'd5, 8'hee));
      emit(enc_jump(1'b0, 4'd13, 8'hf0));  // 0xa5, not taken
      // JZ loop, exits through its own test
      emit(enc_loadi(4'd6, 8'd2));
      emit(enc_loadi(4'd7, 8'd0));
      loop = wp;
      emit(enc_jump(1'b0, 4'd6, loop + 3));
      emit(enc_alu(3'd3, 4'd6, 4'd6, 4'd2));
      emit(enc_jump(1'b0, 4'd7, loop));
      // read back every register
      for (int r = 0; r < `CPU_REG_CNT; r++)
         emit(enc_alu(3'd4, 4'(r), 4'(r), 4'(r)));
      emit(16'hf000);
      prog_len = wp;
      rom_ready = 1'b1;
   end

   always @(posedge clk)
      code <= rom[next_pc];

   always @(negedge clk) begin : compare
      expect_t want;
      if (rst_n) begin
         want = predict(code, model_pc);
         check_val("pc", pc, model_pc);
         check_val("next_pc", next_pc, want.next_pc);
         check_val("write_en", write_en, want.write_en);
         check_val("imm_en", imm_en, want.imm_en);
         check_val("branch_en", branch_en, want.branch_en);
         if (want.write_en) begin
            check_val("result", result, want.result);
            model_regs[code.f_s] = want.result;
         end
         model_pc = want.next_pc;
         if (code.op == 4'hf)
            stop_cycles++;
         if (stop_cycles == 4)   // STOP held long enough
            end_run();
      end
   end

   initial begin : watchdog
      wait (rom_ready);
      repeat (prog_len * 2 + 20) @(posedge clk);
      abort_run($sformatf("timeout: STOP not held within %0d cycles",
                          prog_len * 2 + 20));
   end

endmodule

// ==== test/tb_clk_gen.sv ====
// ----------------------------------------------------------------------
// 8 ns clock, rst_n low for the first 4 rising edges
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module tb_clk_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;   // released on a rising edge
   end

endmodule
